/* logic/rv_decode_pkg.sv */
// shared RV32E decode definitions; only four machine CSRs exist and register addresses are 4 bits
package rv_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 4;
    localparam int csr_addr_w = 12;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;
    localparam logic [6:0] op_fence  = 7'b0001111;

    // machine CSR addresses
    localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;

    // system instructions with funct3 of zero
    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;
    localparam logic [11:0] f12_mret   = 12'h302;

    localparam logic [xlen-1:0] mcause_ecall = 32'd11;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_e;

    typedef enum logic [2:0] {
        jump_none, jump_jal, jump_jalr, jump_branch, jump_mret, jump_ecall
    } jump_e;

    typedef enum logic [1:0] {gpr_src_imm, gpr_src_pc_plus4, gpr_src_csr} gpr_src_e;
    typedef enum logic [1:0] {csr_src_rs1, csr_src_rs1_or_csr, csr_src_pc} csr_src_e;
    typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_e;
    typedef enum logic [1:0] {fwd_reg, fwd_exe, fwd_mem} fwd_sel_e;

    typedef struct packed {
        alu_op_e   aluop;
        logic      gpr_we;
        gpr_src_e  gpr_src;
        logic      csr_we;
        csr_src_e  csr_src;
        jump_e     jump;
        imm_type_e imm_type;
        logic      alu_a_pc;
        logic      alu_b_imm;
        mem_op_e   mem_op;
        logic [2:0] mem_mask;
        logic      rs1_ren;
        logic      rs2_ren;
        logic      is_ebreak;
        logic      is_fence_i;
        logic      is_ecall;
    } ctrl_t;

    typedef struct packed {
        logic                  gpr_we;
        logic [reg_addr_w-1:0] gpr_addr;
        logic [xlen-1:0]       gpr_data;
        logic                  csr_we;
        logic [csr_addr_w-1:0] csr_addr;
        logic [xlen-1:0]       csr_data;
        logic                  trap;
    } wb_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] gpr_waddr;
        logic [csr_addr_w-1:0] csr_waddr;
        logic [xlen-1:0]       alu_a;
        logic [xlen-1:0]       alu_b;
        logic [xlen-1:0]       pc_plus_imm;
        logic [xlen-1:0]       next_pc;
        logic [xlen-1:0]       pc_plus4;
        logic [xlen-1:0]       wdata_gpr;
        logic [xlen-1:0]       wdata_csr;
    } id_ex_t;

endpackage

/* logic/gpr_file.sv */
// 16 x 32 register file; reads do not bypass a same-cycle write, contents are undefined after reset
`timescale 1ns/1ps

module gpr_file (
    input  logic                                clk_i,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_decode_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_decode_pkg::xlen-1:0]       rs2_data_o,
    input  logic                                we_i,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [rv_decode_pkg::xlen-1:0]       wdata_i
);
    import rv_decode_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    // x0 is never written
    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero regardless of array contents
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* logic/csr_file.sv */
// machine CSRs mstatus, mtvec, mepc, mcause only; other addresses read zero and ignore writes
`timescale 1ns/1ps

module csr_file (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [rv_decode_pkg::csr_addr_w-1:0] raddr_i,
    output logic [rv_decode_pkg::xlen-1:0]       rdata_o,
    input  logic                                we_i,
    input  logic [rv_decode_pkg::csr_addr_w-1:0] waddr_i,
    input  logic [rv_decode_pkg::xlen-1:0]       wdata_i,
    input  logic                                trap_i,
    output logic [rv_decode_pkg::xlen-1:0]       mtvec_o,
    output logic [rv_decode_pkg::xlen-1:0]       mepc_o
);
    import rv_decode_pkg::*;

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap_i) begin
            // trap takes priority, wdata carries the faulting pc
            mepc_q   <= wdata_i;
            mcause_q <= mcause_ecall;
        end else if (we_i) begin
            case (waddr_i)
                csr_mstatus: mstatus_q <= wdata_i;
                csr_mtvec:   mtvec_q   <= wdata_i;
                csr_mepc:    mepc_q    <= wdata_i;
                csr_mcause:  mcause_q  <= wdata_i;
                default:     ;
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            csr_mstatus: rdata_o = mstatus_q;
            csr_mtvec:   rdata_o = mtvec_q;
            csr_mepc:    rdata_o = mepc_q;
            csr_mcause:  rdata_o = mcause_q;
            default:     rdata_o = '0;
        endcase
    end

    // trap vector and return address go straight to fetch
    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

/* logic/decode_ctrl.sv */
// RV32E control decoder; illegal encodings are not trapped, unknown opcodes decode to a no-op
`timescale 1ns/1ps

module decode_ctrl (
    input  logic [rv_decode_pkg::xlen-1:0] instr_i,
    output rv_decode_pkg::ctrl_t           ctrl_o
);
    import rv_decode_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign funct12 = instr_i[31:20];

    // alt selects sub/sra, only meaningful where the caller allows it
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.aluop    = alu_add;
        ctrl_o.gpr_src  = gpr_src_imm;
        ctrl_o.csr_src  = csr_src_rs1;
        ctrl_o.jump     = jump_none;
        ctrl_o.imm_type = imm_i;
        ctrl_o.mem_op   = mem_none;

        case (opcode)
            op_lui: begin
                ctrl_o.gpr_we    = 1'b1;
                ctrl_o.imm_type  = imm_u;
                ctrl_o.alu_b_imm = 1'b1;
                ctrl_o.aluop     = alu_pass_b;
            end
            op_auipc: begin
                ctrl_o.gpr_we    = 1'b1;
                ctrl_o.imm_type  = imm_u;
                ctrl_o.alu_a_pc  = 1'b1;
                ctrl_o.alu_b_imm = 1'b1;
            end
            op_jal: begin
                ctrl_o.gpr_we   = 1'b1;
                ctrl_o.gpr_src  = gpr_src_pc_plus4;
                ctrl_o.jump     = jump_jal;
                ctrl_o.imm_type = imm_j;
            end
            op_jalr: begin
                ctrl_o.gpr_we  = 1'b1;
                ctrl_o.gpr_src = gpr_src_pc_plus4;
                ctrl_o.jump    = jump_jalr;
                ctrl_o.rs1_ren = 1'b1;
            end
            op_branch: begin
                // comparison done as sub for eq/ne, slt(u) for the ordered ones
                ctrl_o.jump     = jump_branch;
                ctrl_o.imm_type = imm_b;
                ctrl_o.rs1_ren  = 1'b1;
                ctrl_o.rs2_ren  = 1'b1;
                ctrl_o.aluop    = funct3[2] ? (funct3[1] ? alu_sltu : alu_slt) : alu_sub;
            end
            op_load: begin
                ctrl_o.gpr_we    = 1'b1;
                ctrl_o.mem_op    = mem_read;
                ctrl_o.mem_mask  = funct3;
                ctrl_o.alu_b_imm = 1'b1;
                ctrl_o.rs1_ren   = 1'b1;
            end
            op_store: begin
                ctrl_o.mem_op    = mem_write;
                ctrl_o.mem_mask  = funct3;
                ctrl_o.imm_type  = imm_s;
                ctrl_o.alu_b_imm = 1'b1;
                ctrl_o.rs1_ren   = 1'b1;
                ctrl_o.rs2_ren   = 1'b1;
            end
            op_imm: begin
                ctrl_o.gpr_we    = 1'b1;
                ctrl_o.alu_b_imm = 1'b1;
                ctrl_o.rs1_ren   = 1'b1;
                // only srai uses funct7, addi has no sub form
                ctrl_o.aluop     = alu_from_f3(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            op_reg: begin
                ctrl_o.gpr_we  = 1'b1;
                ctrl_o.rs1_ren = 1'b1;
                ctrl_o.rs2_ren = 1'b1;
                ctrl_o.aluop   = alu_from_f3(funct3, funct7[5]);
            end
            op_system: begin
                case (funct3)
                    3'b000: begin
                        if (funct12 == f12_ecall) begin
                            ctrl_o.jump     = jump_ecall;
                            ctrl_o.csr_src  = csr_src_pc;
                            ctrl_o.is_ecall = 1'b1;
                        end else if (funct12 == f12_ebreak) begin
                            ctrl_o.is_ebreak = 1'b1;
                        end else if (funct12 == f12_mret) begin
                            ctrl_o.jump = jump_mret;
                        end
                    end
                    3'b001, 3'b010: begin
                        // csrrw / csrrs, old value goes to rd
                        ctrl_o.gpr_we  = 1'b1;
                        ctrl_o.gpr_src = gpr_src_csr;
                        ctrl_o.csr_we  = 1'b1;
                        ctrl_o.csr_src = funct3[1] ? csr_src_rs1_or_csr : csr_src_rs1;
                        ctrl_o.rs1_ren = 1'b1;
                    end
                    default: ;
                endcase
            end
            op_fence: begin
                ctrl_o.is_fence_i = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

endmodule

/* logic/operand_sel.sv */
// operand datapath of decode; fwd select value 3 yields zero, mret target is mepc as currently held
`timescale 1ns/1ps

module operand_sel (
    input  logic [rv_decode_pkg::xlen-1:0] instr_i,
    input  logic [rv_decode_pkg::xlen-1:0] pc_i,
    input  rv_decode_pkg::ctrl_t           ctrl_i,
    input  logic [rv_decode_pkg::xlen-1:0] rs1_data_i,
    input  logic [rv_decode_pkg::xlen-1:0] rs2_data_i,
    input  logic [rv_decode_pkg::xlen-1:0] csr_rdata_i,
    input  logic [rv_decode_pkg::xlen-1:0] mepc_i,
    input  rv_decode_pkg::fwd_sel_e        fwd_a_i,
    input  rv_decode_pkg::fwd_sel_e        fwd_b_i,
    input  logic [rv_decode_pkg::xlen-1:0] exe_fwd_data_i,
    input  logic [rv_decode_pkg::xlen-1:0] mem_fwd_data_i,
    output logic [rv_decode_pkg::xlen-1:0] alu_a_o,
    output logic [rv_decode_pkg::xlen-1:0] alu_b_o,
    output logic [rv_decode_pkg::xlen-1:0] pc_plus_imm_o,
    output logic [rv_decode_pkg::xlen-1:0] next_pc_o,
    output logic [rv_decode_pkg::xlen-1:0] pc_plus4_o,
    output logic [rv_decode_pkg::xlen-1:0] wdata_gpr_o,
    output logic [rv_decode_pkg::xlen-1:0] wdata_csr_o
);
    import rv_decode_pkg::*;

    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_fwd;
    logic [xlen-1:0] rs2_fwd;

    // sign-extended immediate by format
    always_comb begin
        case (ctrl_i.imm_type)
            imm_s:   imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            imm_b:   imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            imm_u:   imm = {instr_i[31:12], 12'b0};
            imm_j:   imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            default: imm = {{21{instr_i[31]}}, instr_i[30:20]};
        endcase
    end

    always_comb begin
        case (fwd_a_i)
            fwd_reg: rs1_fwd = rs1_data_i;
            fwd_exe: rs1_fwd = exe_fwd_data_i;
            fwd_mem: rs1_fwd = mem_fwd_data_i;
            default: rs1_fwd = '0;
        endcase
        case (fwd_b_i)
            fwd_reg: rs2_fwd = rs2_data_i;
            fwd_exe: rs2_fwd = exe_fwd_data_i;
            fwd_mem: rs2_fwd = mem_fwd_data_i;
            default: rs2_fwd = '0;
        endcase
    end

    assign alu_a_o       = ctrl_i.alu_a_pc ? pc_i : rs1_fwd;
    assign alu_b_o       = ctrl_i.alu_b_imm ? imm : rs2_fwd;
    assign pc_plus_imm_o = pc_i + imm;
    assign pc_plus4_o    = pc_i + 32'd4;

    // jal and branch targets come from pc_plus_imm in execute
    always_comb begin
        case (ctrl_i.jump)
            jump_jalr: next_pc_o = (rs1_fwd + imm) & ~32'd1;
            jump_mret: next_pc_o = mepc_i;
            default:   next_pc_o = pc_plus4_o;
        endcase
    end

    always_comb begin
        if (ctrl_i.mem_op == mem_write) begin
            wdata_gpr_o = rs2_fwd;
        end else begin
            case (ctrl_i.gpr_src)
                gpr_src_csr:      wdata_gpr_o = csr_rdata_i;
                gpr_src_pc_plus4: wdata_gpr_o = pc_plus4_o;
                default:          wdata_gpr_o = imm;
            endcase
        end
    end

    // ecall passes its own pc on for mepc
    always_comb begin
        case (ctrl_i.csr_src)
            csr_src_rs1_or_csr: wdata_csr_o = csr_rdata_i | rs1_fwd;
            csr_src_rs1:        wdata_csr_o = rs1_fwd;
            default:            wdata_csr_o = pc_i;
        endcase
    end

endmodule

/* logic/decode_stage.sv */
// RV32E decode stage; fully combinational to execute, holds no instruction, writes land one edge later
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic [rv_decode_pkg::xlen-1:0] instr_i,
    input  logic [rv_decode_pkg::xlen-1:0] pc_i,
    input  logic                           in_valid_i,
    output logic                           in_ready_o,
    output logic                           out_valid_o,
    input  logic                           out_ready_i,
    input  logic                           stall_i,
    input  rv_decode_pkg::wb_t             wb_i,
    input  rv_decode_pkg::fwd_sel_e        fwd_a_i,
    input  rv_decode_pkg::fwd_sel_e        fwd_b_i,
    input  logic [rv_decode_pkg::xlen-1:0] exe_fwd_data_i,
    input  logic [rv_decode_pkg::xlen-1:0] mem_fwd_data_i,
    output rv_decode_pkg::id_ex_t          id_ex_o,
    output logic [rv_decode_pkg::xlen-1:0] mtvec_o,
    output logic                           ebreak_o,
    output logic                           fence_i_o
);
    import rv_decode_pkg::*;

    ctrl_t           ctrl;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] mepc;

    // a hazard stall blocks both directions of the handshake
    assign out_valid_o = in_valid_i & ~stall_i;
    assign in_ready_o  = out_ready_i & ~stall_i;

    gpr_file u_gpr (
        .clk_i      (clk_i),
        .rs1_addr_i (instr_i[15 +: reg_addr_w]),
        .rs2_addr_i (instr_i[20 +: reg_addr_w]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_i.gpr_we),
        .waddr_i    (wb_i.gpr_addr),
        .wdata_i    (wb_i.gpr_data)
    );

    csr_file u_csr (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .raddr_i (instr_i[31:20]),
        .rdata_o (csr_rdata),
        .we_i    (wb_i.csr_we),
        .waddr_i (wb_i.csr_addr),
        .wdata_i (wb_i.csr_data),
        .trap_i  (wb_i.trap),
        .mtvec_o (mtvec_o),
        .mepc_o  (mepc)
    );

    decode_ctrl u_ctrl (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    operand_sel u_opsel (
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .ctrl_i         (ctrl),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .csr_rdata_i    (csr_rdata),
        .mepc_i         (mepc),
        .fwd_a_i        (fwd_a_i),
        .fwd_b_i        (fwd_b_i),
        .exe_fwd_data_i (exe_fwd_data_i),
        .mem_fwd_data_i (mem_fwd_data_i),
        .alu_a_o        (id_ex_o.alu_a),
        .alu_b_o        (id_ex_o.alu_b),
        .pc_plus_imm_o  (id_ex_o.pc_plus_imm),
        .next_pc_o      (id_ex_o.next_pc),
        .pc_plus4_o     (id_ex_o.pc_plus4),
        .wdata_gpr_o    (id_ex_o.wdata_gpr),
        .wdata_csr_o    (id_ex_o.wdata_csr)
    );

    assign id_ex_o.ctrl      = ctrl;
    assign id_ex_o.gpr_waddr = instr_i[7 +: reg_addr_w];
    assign id_ex_o.csr_waddr = instr_i[31:20];

    // icache flush only for a real instruction
    assign fence_i_o = in_valid_i & ctrl.is_fence_i;
    assign ebreak_o  = ctrl.is_ebreak;

endmodule

/* tests/tb_decode_stage.sv */
// decode stage outputs are combinational, so each check runs 1 ns after its falling-edge drive
`timescale 1ns/1ps

module tb_decode_stage;
    import rv_decode_pkg::*;

    localparam int reset_cycles    = 4;
    localparam int test_count      = 6;
    localparam int cycles_per_test = 32;
    localparam int max_cycles      = reset_cycles + test_count * cycles_per_test;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        in_valid;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    logic        stall;
    wb_t         wb;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic [31:0] exe_fwd_data;
    logic [31:0] mem_fwd_data;
    id_ex_t      id_ex;
    logic [31:0] mtvec;
    logic        ebreak;
    logic        fence_i;

    // expected register contents, updated with every write
    logic [31:0] model_regs [16];
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          error_count;
    int          check_count;
    int          tests_run;
    int          tests_failed;

    decode_stage dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_i        (instr),
        .pc_i           (pc),
        .in_valid_i     (in_valid),
        .in_ready_o     (in_ready),
        .out_valid_o    (out_valid),
        .out_ready_i    (out_ready),
        .stall_i        (stall),
        .wb_i           (wb),
        .fwd_a_i        (fwd_a),
        .fwd_b_i        (fwd_b),
        .exe_fwd_data_i (exe_fwd_data),
        .mem_fwd_data_i (mem_fwd_data),
        .id_ex_o        (id_ex),
        .mtvec_o        (mtvec),
        .ebreak_o       (ebreak),
        .fence_i_o      (fence_i)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[31]};
        end
    endtask

    // RV32E register fields are 4 bits wide
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [3:0] rs2,
                                           input logic [3:0] rs1, input logic [2:0] f3,
                                           input logic [3:0] rd, input logic [6:0] op);
        return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [3:0] rs1,
                                           input logic [2:0] f3, input logic [3:0] rd,
                                           input logic [6:0] op);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [3:0] rs2,
                                           input logic [3:0] rs1, input logic [2:0] f3);
        return {imm[11:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [3:0] rd,
                                           input logic [6:0] op);
        return {imm, 1'b0, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [3:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, op_jal};
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (error_count == start_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - start_errors);
            tests_failed++;
        end
    endtask

    task automatic apply_instr(input logic [31:0] i, input logic [31:0] p);
        @(negedge clk);
        instr = i;
        pc    = p;
        #1;
    endtask

    // write lands on the rising edge between the two falling edges
    task automatic write_gpr(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        wb          = '0;
        wb.gpr_we   = 1'b1;
        wb.gpr_addr = addr;
        wb.gpr_data = data;
        @(negedge clk);
        wb = '0;
        if (addr != 4'd0) begin
            model_regs[addr] = data;
        end
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        wb          = '0;
        wb.csr_we   = 1'b1;
        wb.csr_addr = addr;
        wb.csr_data = data;
        @(negedge clk);
        wb = '0;
    endtask

    task automatic gpr_readback();
        int          start_errors;
        logic [31:0] value;
        start_errors = error_count;
        for (int r = 1; r < 16; r += 3) begin
            rand_word(value);
            write_gpr(r[3:0], value);
        end
        apply_instr(r_type(7'd0, 4'd4, 4'd1, 3'b000, 4'd2, op_reg), 32'h100);
        expect_eq("add x2, x1, x4 alu_a", id_ex.alu_a, model_regs[1]);
        expect_eq("add x2, x1, x4 alu_b", id_ex.alu_b, model_regs[4]);
        apply_instr(r_type(7'd0, 4'd10, 4'd7, 3'b000, 4'd3, op_reg), 32'h104);
        expect_eq("add x3, x7, x10 alu_a", id_ex.alu_a, model_regs[7]);
        expect_eq("add x3, x7, x10 alu_b", id_ex.alu_b, model_regs[10]);
        rand_word(value);
        write_gpr(4'd0, value);
        apply_instr(r_type(7'd0, 4'd13, 4'd0, 3'b000, 4'd2, op_reg), 32'h108);
        expect_eq("x0 after write", id_ex.alu_a, 32'd0);
        expect_eq("add x2, x0, x13 alu_b", id_ex.alu_b, model_regs[13]);
        finish_test("register writeback and read", start_errors);
    endtask

    task automatic immediate_forms();
        int start_errors;
        start_errors = error_count;
        apply_instr(i_type(12'hFFB, 4'd7, 3'b000, 4'd6, op_imm), 32'h200);
        expect_eq("addi alu_a", id_ex.alu_a, model_regs[7]);
        expect_eq("addi -5 alu_b", id_ex.alu_b, 32'hFFFF_FFFB);
        apply_instr(u_type(20'h80001, 4'd6, op_auipc), 32'h0000_1000);
        expect_eq("auipc alu_a", id_ex.alu_a, 32'h0000_1000);
        expect_eq("auipc pc_plus_imm", id_ex.pc_plus_imm, 32'h8000_2000);
        // jump back by 16 bytes
        apply_instr(j_type(21'h1FFFF0, 4'd1), 32'h0000_2000);
        expect_eq("jal wdata_gpr", id_ex.wdata_gpr, 32'h0000_2004);
        expect_eq("jal pc_plus_imm", id_ex.pc_plus_imm, 32'h0000_1FF0);
        expect_eq("jal pc_plus4", id_ex.pc_plus4, 32'h0000_2004);
        expect_eq("jal gpr_waddr", 32'(id_ex.gpr_waddr), 32'd1);
        apply_instr(s_type(12'd8, 4'd10, 4'd13, 3'b010), 32'h300);
        expect_eq("sw wdata_gpr", id_ex.wdata_gpr, model_regs[10]);
        expect_eq("sw alu_b", id_ex.alu_b, 32'd8);
        expect_eq("sw mem_op", 32'(id_ex.ctrl.mem_op), 32'(mem_write));
        finish_test("immediates and operand sources", start_errors);
    endtask

    task automatic forwarding_paths();
        int          start_errors;
        fwd_sel_e    choices [3];
        logic [31:0] a_vals [3];
        logic [31:0] b_vals [3];
        start_errors = error_count;
        choices[0] = fwd_reg;
        choices[1] = fwd_exe;
        choices[2] = fwd_mem;
        rand_word(a_vals[1]);
        rand_word(a_vals[2]);
        a_vals[0] = model_regs[1];
        b_vals    = a_vals;
        b_vals[0] = model_regs[4];
        @(negedge clk);
        exe_fwd_data = a_vals[1];
        mem_fwd_data = a_vals[2];
        instr        = r_type(7'd0, 4'd4, 4'd1, 3'b000, 4'd2, op_reg);
        for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 3; b++) begin
                @(negedge clk);
                fwd_a = choices[a];
                fwd_b = choices[b];
                #1;
                expect_eq($sformatf("alu_a with select %0d", a), id_ex.alu_a, a_vals[a]);
                expect_eq($sformatf("alu_b with select %0d", b), id_ex.alu_b, b_vals[b]);
            end
        end
        @(negedge clk);
        fwd_a = fwd_reg;
        fwd_b = fwd_reg;
        finish_test("forwarding", start_errors);
    endtask

    task automatic csr_access();
        int          start_errors;
        logic [31:0] vec_val;
        logic [31:0] epc_val;
        logic [31:0] trap_pc;
        start_errors = error_count;
        rand_word(vec_val);
        rand_word(epc_val);
        rand_word(trap_pc);
        @(negedge clk);
        wb          = '0;
        wb.csr_we   = 1'b1;
        wb.csr_addr = csr_mtvec;
        wb.csr_data = vec_val;
        #1;
        expect_eq("mtvec before write edge", mtvec, 32'd0);
        @(negedge clk);
        wb = '0;
        #1;
        expect_eq("mtvec after write edge", mtvec, vec_val);
        write_csr(csr_mepc, epc_val);
        apply_instr(i_type(csr_mtvec, 4'd7, 3'b010, 4'd1, op_system), 32'h400);
        expect_eq("csrrs wdata_gpr", id_ex.wdata_gpr, vec_val);
        expect_eq("csrrs wdata_csr", id_ex.wdata_csr, vec_val | model_regs[7]);
        expect_eq("csrrs csr_waddr", 32'(id_ex.csr_waddr), 32'h305);
        expect_eq("csrrs gpr_waddr", 32'(id_ex.gpr_waddr), 32'd1);
        apply_instr(i_type(f12_mret, 4'd0, 3'b000, 4'd0, op_system), 32'h404);
        expect_eq("mret next_pc", id_ex.next_pc, epc_val);
        // trap carries the faulting pc on csr_data
        @(negedge clk);
        wb          = '0;
        wb.trap     = 1'b1;
        wb.csr_data = trap_pc;
        @(negedge clk);
        wb = '0;
        apply_instr(i_type(csr_mepc, 4'd0, 3'b010, 4'd1, op_system), 32'h408);
        expect_eq("mepc after trap", id_ex.wdata_gpr, trap_pc);
        apply_instr(i_type(csr_mcause, 4'd0, 3'b010, 4'd1, op_system), 32'h40C);
        expect_eq("mcause after trap", id_ex.wdata_gpr, 32'd11);
        finish_test("CSR path", start_errors);
    endtask

    task automatic jalr_target();
        int          start_errors;
        logic [31:0] base;
        logic [11:0] offset;
        logic [31:0] sum;
        logic [10:0] highs [2];
        start_errors = error_count;
        highs[0] = 11'h015;
        highs[1] = 11'h7C0;
        base     = model_regs[10];
        for (int k = 0; k < 2; k++) begin
            // low offset bit opposite to the base bit, so the sum is odd
            offset = {highs[k], ~base[0]};
            sum    = base + {{20{offset[11]}}, offset};
            apply_instr(i_type(offset, 4'd10, 3'b000, 4'd1, op_jalr), 32'h500);
            expect_eq("jalr next_pc", id_ex.next_pc, {sum[31:1], 1'b0});
        end
        finish_test("jalr target", start_errors);
    endtask

    task automatic handshake_flags();
        int          start_errors;
        logic [31:0] fence_instr;
        start_errors = error_count;
        fence_instr  = i_type(12'd0, 4'd0, 3'b001, 4'd0, op_fence);
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            in_valid  = c[0];
            out_ready = c[1];
            stall     = c[2];
            #1;
            expect_bit($sformatf("out_valid, case %0d", c), out_valid, c[0] & ~c[2]);
            expect_bit($sformatf("in_ready, case %0d", c), in_ready, c[1] & ~c[2]);
        end
        @(negedge clk);
        stall     = 1'b0;
        out_ready = 1'b1;
        in_valid  = 1'b0;
        instr     = fence_instr;
        #1;
        expect_bit("fence_i without valid", fence_i, 1'b0);
        @(negedge clk);
        in_valid = 1'b1;
        #1;
        expect_bit("fence_i with valid", fence_i, 1'b1);
        expect_bit("ebreak on fence.i", ebreak, 1'b0);
        apply_instr(i_type(f12_ebreak, 4'd0, 3'b000, 4'd0, op_system), 32'h600);
        expect_bit("ebreak on ebreak", ebreak, 1'b1);
        apply_instr(i_type(f12_ecall, 4'd0, 3'b000, 4'd0, op_system), 32'h604);
        expect_bit("ebreak on ecall", ebreak, 1'b0);
        expect_eq("ecall wdata_csr", id_ex.wdata_csr, 32'h604);
        apply_instr(r_type(7'd0, 4'd4, 4'd1, 3'b000, 4'd2, op_reg), 32'h608);
        expect_bit("ebreak on add", ebreak, 1'b0);
        finish_test("handshake and flags", start_errors);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr        = i_type(12'd0, 4'd0, 3'b000, 4'd0, op_imm);
        pc           = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        stall        = 1'b0;
        wb           = '0;
        fwd_a        = fwd_reg;
        fwd_b        = fwd_reg;
        exe_fwd_data = '0;
        mem_fwd_data = '0;
        lfsr_state   = 32'd81430;
        cycle_count  = 0;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < 16; r++) begin
            model_regs[r] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b1;
        in_valid  = 1'b1;
        out_ready = 1'b1;

        gpr_readback();
        immediate_forms();
        forwarding_paths();
        csr_access();
        jalr_target();
        handshake_flags();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* decode_stage.f */
logic/rv_decode_pkg.sv
logic/gpr_file.sv
logic/csr_file.sv
logic/decode_ctrl.sv
logic/operand_sel.sv
logic/decode_stage.sv
tests/tb_decode_stage.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= tb_decode_stage
FILELIST ?= decode_stage.f
LOG      ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
